// ==== verilog/modRegsPkg.sv ====
`default_nettype none

package modRegsPkg;

    // register word offsets
    typedef enum logic [11:0] {
        REG_FREQ    = 12'h000,
        REG_DEV     = 12'h004,
        REG_BITRATE = 12'h008
    } regAddr;

    localparam logic [1:0] RESP_OKAY   = 2'b00;
    localparam logic [1:0] RESP_SLVERR = 2'b10;

    // master side of the AXI4-Lite port
    typedef struct packed {
        logic [11:0] awaddr;
        logic        awvalid;
        logic [31:0] wdata;
        logic [3:0]  wstrb;
        logic        wvalid;
        logic        bready;
        logic [11:0] araddr;
        logic        arvalid;
        logic        rready;
    } axiReq;

    typedef struct packed {
        logic        awready;
        logic        wready;
        logic        bvalid;
        logic [1:0]  bresp;
        logic        arready;
        logic        rvalid;
        logic [31:0] rdata;
        logic [1:0]  rresp;
    } axiRsp;

    typedef struct packed {
        logic [31:0] carrierFreq;
        logic [17:0] deviation;  // unsigned magnitude
        logic [15:0] bitrateDiv;
        logic        modEnable;
    } modConfig;

endpackage

`default_nettype wire

// ==== verilog/soqpskPkg.sv ====
`default_nettype none

package soqpskPkg;

    // ternary symbol, two's complement coded
    typedef enum logic [1:0] {
        symZero = 2'b00,
        symPos  = 2'b01,
        symNeg  = 2'b11
    } soqpskSym;

    typedef enum logic {
        parityEven = 1'b0,
        parityOdd  = 1'b1
    } bitParity;

    // precoder output beat
    typedef struct packed {
        soqpskSym sym;
        logic     valid;  // high once a real symbol is held
    } symBeat;

endpackage

`default_nettype wire

// ==== verilog/soqpskModRegs.sv ====
`default_nettype none

module soqpskModRegs #(
    parameter int ADDR_W = 12
) (
    input  wire logic                 clk,
    input  wire logic                 arstN,
    input  wire modRegsPkg::axiReq    axiReq,
    output modRegsPkg::axiRsp         axiResp,
    output modRegsPkg::modConfig      cfg
);

    localparam logic [ADDR_W-1:0] ADDR_FREQ    = ADDR_W'(modRegsPkg::REG_FREQ);
    localparam logic [ADDR_W-1:0] ADDR_DEV     = ADDR_W'(modRegsPkg::REG_DEV);
    localparam logic [ADDR_W-1:0] ADDR_BITRATE = ADDR_W'(modRegsPkg::REG_BITRATE);

    modRegsPkg::modConfig cfgQ;

    logic              readyEn;
    logic [ADDR_W-1:0] wrAddr;
    logic [ADDR_W-1:0] rdAddr;
    logic              wrAccept;
    logic              rdAccept;
    logic              bvalidQ;
    logic [1:0]        brespQ;
    logic              rvalidQ;
    logic [31:0]       rdataQ;
    logic [1:0]        rrespQ;
    logic [31:0]       rdMux;
    logic              rdErr;

    assign wrAddr = axiReq.awaddr[ADDR_W-1:0];
    assign rdAddr = axiReq.araddr[ADDR_W-1:0];

    // both write channels are taken on the same edge
    assign wrAccept = readyEn & axiReq.awvalid & axiReq.wvalid & ~bvalidQ;
    assign rdAccept = readyEn & axiReq.arvalid & ~rvalidQ;

    always_comb begin
        axiResp         = '0;
        axiResp.awready = wrAccept;
        axiResp.wready  = wrAccept;
        axiResp.bvalid  = bvalidQ;
        axiResp.bresp   = brespQ;
        axiResp.arready = readyEn & ~rvalidQ;
        axiResp.rvalid  = rvalidQ;
        axiResp.rdata   = rdataQ;
        axiResp.rresp   = rrespQ;
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            readyEn <= 1'b0;
        end else begin
            readyEn <= 1'b1;  // ports open the cycle after reset
        end
    end

    // write path with per-lane strobes
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            cfgQ    <= '0;
            bvalidQ <= 1'b0;
            brespQ  <= modRegsPkg::RESP_OKAY;
        end else if (wrAccept) begin
            bvalidQ <= 1'b1;
            brespQ  <= modRegsPkg::RESP_OKAY;
            case (wrAddr)
                ADDR_FREQ: begin
                    for (int i = 0; i < 4; i++) begin
                        if (axiReq.wstrb[i]) begin
                            cfgQ.carrierFreq[8*i +: 8] <= axiReq.wdata[8*i +: 8];
                        end
                    end
                end
                ADDR_DEV: begin
                    if (axiReq.wstrb[0]) cfgQ.deviation[7:0] <= axiReq.wdata[7:0];
                    if (axiReq.wstrb[1]) cfgQ.deviation[15:8] <= axiReq.wdata[15:8];
                    if (axiReq.wstrb[2]) cfgQ.deviation[17:16] <= axiReq.wdata[17:16];
                end
                ADDR_BITRATE: begin
                    if (axiReq.wstrb[0]) cfgQ.bitrateDiv[7:0] <= axiReq.wdata[7:0];
                    if (axiReq.wstrb[1]) cfgQ.bitrateDiv[15:8] <= axiReq.wdata[15:8];
                    if (axiReq.wstrb[3]) cfgQ.modEnable <= axiReq.wdata[31];
                end
                default: brespQ <= modRegsPkg::RESP_SLVERR;  // nothing written
            endcase
        end else if (bvalidQ && axiReq.bready) begin
            bvalidQ <= 1'b0;
        end
    end

    always_comb begin
        rdMux = '0;
        rdErr = 1'b0;
        case (rdAddr)
            ADDR_FREQ:    rdMux = cfgQ.carrierFreq;
            ADDR_DEV:     rdMux = {14'd0, cfgQ.deviation};
            ADDR_BITRATE: rdMux = {cfgQ.modEnable, 15'd0, cfgQ.bitrateDiv};
            default:      rdErr = 1'b1;
        endcase
    end

    // read data held stable until rready
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            rvalidQ <= 1'b0;
            rdataQ  <= '0;
            rrespQ  <= modRegsPkg::RESP_OKAY;
        end else if (rdAccept) begin
            rvalidQ <= 1'b1;
            rdataQ  <= rdMux;
            rrespQ  <= rdErr ? modRegsPkg::RESP_SLVERR : modRegsPkg::RESP_OKAY;
        end else if (rvalidQ && axiReq.rready) begin
            rvalidQ <= 1'b0;
        end
    end

    assign cfg = cfgQ;

endmodule

`default_nettype wire

// ==== verilog/bitClockGen.sv ====
`default_nettype none

module bitClockGen (
    input  wire logic                 clk,
    input  wire logic                 arstN,
    input  wire modRegsPkg::modConfig cfg,
    output logic                      bitStrobe
);

    logic [15:0] cnt;

    // strobe on the zero count, period is bitrateDiv + 1
    assign bitStrobe = cfg.modEnable && (cnt == '0);

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            cnt <= '0;
        end else if (!cfg.modEnable) begin
            cnt <= '0;  // known phase for the next enable
        end else if (cnt == '0) begin
            cnt <= cfg.bitrateDiv;
        end else begin
            cnt <= cnt - 16'd1;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/soqpskPrecoder.sv ====
`default_nettype none

module soqpskPrecoder (
    input  wire logic          clk,
    input  wire logic          arstN,
    input  wire logic          bitStrobe,
    input  wire logic          dataBit,
    input  wire logic          modEnable,
    output soqpskPkg::symBeat  symOut
);

    logic                a1;  // previous bit
    logic                a2;  // bit before that
    soqpskPkg::bitParity parity;
    soqpskPkg::soqpskSym symNext;
    logic                negSign;

    // plus for a one, flipped for a1 low, flipped again on even parity
    assign negSign = ~dataBit ^ ~a1 ^ (parity == soqpskPkg::parityEven);

    always_comb begin
        if (dataBit == a2) begin
            symNext = soqpskPkg::symZero;
        end else begin
            symNext = negSign ? soqpskPkg::symNeg : soqpskPkg::symPos;
        end
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            a1           <= 1'b0;
            a2           <= 1'b0;
            parity       <= soqpskPkg::parityEven;
            symOut.sym   <= soqpskPkg::symZero;
            symOut.valid <= 1'b0;
        end else if (!modEnable) begin
            a1           <= 1'b0;
            a2           <= 1'b0;
            parity       <= soqpskPkg::parityEven;
            symOut.sym   <= soqpskPkg::symZero;
            symOut.valid <= 1'b0;
        end else if (bitStrobe) begin
            a2           <= a1;
            a1           <= dataBit;
            parity       <= (parity == soqpskPkg::parityEven) ?
                            soqpskPkg::parityOdd : soqpskPkg::parityEven;
            symOut.sym   <= symNext;
            symOut.valid <= 1'b1;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/phaseAccum.sv ====
`default_nettype none

module phaseAccum #(
    parameter int PHASE_W = 32
) (
    input  wire logic                 clk,
    input  wire logic                 arstN,
    input  wire modRegsPkg::modConfig cfg,
    input  wire soqpskPkg::symBeat    symIn,
    output logic [PHASE_W-1:0]        instFreq,
    output logic [PHASE_W-1:0]        phase
);

    logic [PHASE_W-1:0] carrier;
    logic [PHASE_W-1:0] dev;
    logic [PHASE_W-1:0] freqSel;

    assign carrier = PHASE_W'(cfg.carrierFreq);
    assign dev     = PHASE_W'(cfg.deviation);

    // wraps mod 2^PHASE_W
    always_comb begin
        freqSel = carrier;
        if (symIn.valid) begin
            case (symIn.sym)
                soqpskPkg::symPos: freqSel = carrier + dev;
                soqpskPkg::symNeg: freqSel = carrier - dev;
                default:           freqSel = carrier;
            endcase
        end
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            instFreq <= '0;
            phase    <= '0;
        end else begin
            instFreq <= freqSel;
            phase    <= phase + instFreq;  // last cycle's frequency
        end
    end

endmodule

`default_nettype wire

// ==== verilog/soqpskModTop.sv ====
`default_nettype none

module soqpskModTop #(
    parameter int ADDR_W  = 12,
    parameter int PHASE_W = 32
) (
    input  wire logic              clk,
    input  wire logic              arstN,
    input  wire modRegsPkg::axiReq axiReq,
    output modRegsPkg::axiRsp      axiResp,
    input  wire logic              dataBit,
    output logic                   bitStrobe,
    output logic [PHASE_W-1:0]     instFreq,
    output logic [PHASE_W-1:0]     phase
);

    modRegsPkg::modConfig cfg;
    soqpskPkg::symBeat    symBeat;

    soqpskModRegs #(
        .ADDR_W (ADDR_W)
    ) soqpskModRegs_i (
        .clk     (clk),
        .arstN   (arstN),
        .axiReq  (axiReq),
        .axiResp (axiResp),
        .cfg     (cfg)
    );

    bitClockGen bitClockGen_i (
        .clk       (clk),
        .arstN     (arstN),
        .cfg       (cfg),
        .bitStrobe (bitStrobe)
    );

    soqpskPrecoder soqpskPrecoder_i (
        .clk       (clk),
        .arstN     (arstN),
        .bitStrobe (bitStrobe),
        .dataBit   (dataBit),
        .modEnable (cfg.modEnable),
        .symOut    (symBeat)
    );

    phaseAccum #(
        .PHASE_W (PHASE_W)
    ) phaseAccum_i (
        .clk      (clk),
        .arstN    (arstN),
        .cfg      (cfg),
        .symIn    (symBeat),
        .instFreq (instFreq),
        .phase    (phase)
    );

endmodule

`default_nettype wire

// ==== test/soqpskModChk.sv ====
`default_nettype none

module soqpskModChk (
    input wire logic              clk,
    input wire logic              arstN,
    input wire modRegsPkg::axiReq axiReq,
    input wire modRegsPkg::axiRsp axiResp,
    input wire logic              bitStrobe,
    input wire logic              modEnable
);

    bvalidHold: assert property (@(posedge clk) disable iff (!arstN)
        axiResp.bvalid && !axiReq.bready |=> axiResp.bvalid)
        else $error("bvalid dropped before bready");

    // read data must not move while the master stalls
    rvalidHold: assert property (@(posedge clk) disable iff (!arstN)
        axiResp.rvalid && !axiReq.rready |=> axiResp.rvalid && $stable(axiResp.rdata))
        else $error("rvalid or rdata changed before rready");

    // counter is held at zero, so the first enabled cycle strobes
    strobeQuiet: assert property (@(posedge clk) disable iff (!arstN)
        !modEnable |-> !bitStrobe ##1 (!modEnable || bitStrobe))
        else $error("bitStrobe high while disabled or missing on the first enabled cycle");

    awreadyBlocked: assert property (@(posedge clk) disable iff (!arstN)
        axiResp.awready |-> !axiResp.bvalid ##1 axiResp.bvalid)
        else $error("awready with a write response pending or no response after it");

endmodule

bind soqpskModTop soqpskModChk soqpskModChk_i (
    .clk       (clk),
    .arstN     (arstN),
    .axiReq    (axiReq),
    .axiResp   (axiResp),
    .bitStrobe (bitStrobe),
    .modEnable (cfg.modEnable)
);

`default_nettype wire

// ==== test/soqpskModTb.sv ====
`default_nettype none

module soqpskModTb;

    localparam int PHASE_W  = 32;
    localparam int MAX_DIV  = 6;
    localparam int RUN_BITS = 40;

    typedef enum logic [1:0] {opWrite, opRead, opRun, opIdle} tblOp;

    typedef struct packed {
        tblOp        op;
        logic [11:0] addr;
        logic [31:0] data;  // bit count for run, cycle count for idle
        logic [3:0]  strb;
        logic [31:0] expData;
        logic [1:0]  expResp;
    } tblEntry;

    logic               clk = 1'b0;
    logic               arstN;
    logic               dataBit = 1'b0;
    logic               bitStrobe;
    logic [PHASE_W-1:0] instFreq;
    logic [PHASE_W-1:0] phase;
    modRegsPkg::axiReq  req;
    modRegsPkg::axiRsp  rsp;

    integer             seed = 96;
    int                 cycleCount = 0;
    int                 timeoutLimit = 0;
    int                 strobeCount = 0;
    int                 lastStrobe = 0;
    int                 target;
    logic               haveLast = 1'b0;
    tblEntry            cur;
    logic [31:0]        rdData;
    logic [1:0]         resp;

    // model of the register fields, the precoder history and the phase path
    logic [31:0]         mCarrier = '0;
    logic [17:0]         mDev = '0;
    logic [15:0]         mDiv = '0;
    logic                mEnable = 1'b0;
    logic                mA1 = 1'b0;
    logic                mA2 = 1'b0;
    soqpskPkg::bitParity mParity = soqpskPkg::parityEven;
    soqpskPkg::soqpskSym mSym = soqpskPkg::symZero;  // expected symOut this cycle
    logic [PHASE_W-1:0]  mInst = '0;
    logic [PHASE_W-1:0]  mPhase = '0;

    tblEntry stimTable[$];

    soqpskModTop #(
        .ADDR_W  (12),
        .PHASE_W (PHASE_W)
    ) soqpskModTop_i (
        .clk       (clk),
        .arstN     (arstN),
        .axiReq    (req),
        .axiResp   (rsp),
        .dataBit   (dataBit),
        .bitStrobe (bitStrobe),
        .instFreq  (instFreq),
        .phase     (phase)
    );

    always #4 clk = ~clk;

    task automatic abortRun(input string what);
        $display("%s", what);
        $display("Result: FAILED");
        $fatal(1);
    endtask

    task automatic checkData(input string name, input logic [31:0] act, input logic [31:0] exp);
        if (act !== exp) begin
            abortRun($sformatf("CHECK FAILED %s: got 0x%08h, expected 0x%08h", name, act, exp));
        end
    endtask

    task automatic checkResp(input string name, input logic [1:0] act, input logic [1:0] exp);
        if (act !== exp) begin
            abortRun($sformatf("CHECK FAILED %s: got 0x%01h, expected 0x%01h", name, act, exp));
        end
    endtask

    task automatic checkSym(input string name, input soqpskPkg::soqpskSym act,
                            input soqpskPkg::soqpskSym exp);
        if (act !== exp) begin
            abortRun($sformatf("CHECK FAILED %s: got 0x%01h, expected 0x%01h", name, act, exp));
        end
    endtask

    task automatic checkFreq(input string name, input logic [PHASE_W-1:0] act,
                             input logic [PHASE_W-1:0] exp);
        if (act !== exp) begin
            abortRun($sformatf("CHECK FAILED %s: got 0x%08h, expected 0x%08h", name, act, exp));
        end
    endtask

    function automatic void addEntry(input tblOp op, input logic [11:0] addr,
                                     input logic [31:0] data, input logic [3:0] strb,
                                     input logic [31:0] expData, input logic [1:0] expResp);
        stimTable.push_back('{op, addr, data, strb, expData, expResp});
    endfunction

    function automatic logic [31:0] mergeLanes(input logic [31:0] old, input logic [31:0] data,
                                               input logic [3:0] strb);
        logic [31:0] res;
        res = old;
        for (int i = 0; i < 4; i++) begin
            if (strb[i]) res[8*i +: 8] = data[8*i +: 8];
        end
        return res;
    endfunction

    // register image per the map with lanes past a field's width dropped
    function automatic void modelWrite(input logic [11:0] addr, input logic [31:0] data,
                                       input logic [3:0] strb);
        logic [31:0] img;
        case (addr)
            modRegsPkg::REG_FREQ: mCarrier = mergeLanes(mCarrier, data, strb);
            modRegsPkg::REG_DEV: begin
                img  = mergeLanes({14'd0, mDev}, data, strb);
                mDev = img[17:0];
            end
            modRegsPkg::REG_BITRATE: begin
                img     = mergeLanes({mEnable, 15'd0, mDiv}, data, strb);
                mDiv    = img[15:0];
                mEnable = img[31];
            end
            default: ;
        endcase
    endfunction

    function automatic soqpskPkg::soqpskSym predictSym(input logic b);
        int sign;
        sign = b ? 1 : -1;
        if (!mA1) sign = -sign;
        if (mParity == soqpskPkg::parityEven) sign = -sign;
        if (b == mA2) return soqpskPkg::symZero;
        return (sign > 0) ? soqpskPkg::symPos : soqpskPkg::symNeg;
    endfunction

    function automatic logic [PHASE_W-1:0] freqFor(input soqpskPkg::soqpskSym s);
        logic [PHASE_W-1:0] carrier;
        logic [PHASE_W-1:0] dev;
        carrier = PHASE_W'(mCarrier);
        dev     = PHASE_W'(mDev);
        if (s == soqpskPkg::symPos) return carrier + dev;
        if (s == soqpskPkg::symNeg) return carrier - dev;
        return carrier;
    endfunction

    task automatic axiWrite(input tblEntry e, output logic [1:0] bresp);
        int delay;
        req.awaddr  <= e.addr;
        req.awvalid <= 1'b1;
        req.wdata   <= e.data;
        req.wstrb   <= e.strb;
        req.wvalid  <= 1'b1;
        do @(posedge clk); while (!(rsp.awready && rsp.wready));
        modelWrite(e.addr, e.data, e.strb);  // register changes on this edge
        req.awvalid <= 1'b0;
        req.wvalid  <= 1'b0;
        delay = $unsigned($random(seed)) % 4;
        repeat (delay) @(posedge clk);
        req.bready <= 1'b1;
        do @(posedge clk); while (!rsp.bvalid);
        bresp = rsp.bresp;
        req.bready <= 1'b0;
    endtask

    task automatic axiRead(input logic [11:0] addr, output logic [31:0] data,
                           output logic [1:0] rresp);
        int delay;
        req.araddr  <= addr;
        req.arvalid <= 1'b1;
        do @(posedge clk); while (!rsp.arready);
        req.arvalid <= 1'b0;
        delay = $unsigned($random(seed)) % 4;
        repeat (delay) @(posedge clk);
        req.rready <= 1'b1;
        do @(posedge clk); while (!rsp.rvalid);
        data  = rsp.rdata;
        rresp = rsp.rresp;
        req.rready <= 1'b0;
    endtask

    task automatic buildTable();
        addEntry(opWrite, 12'h000, 32'h1234_5678, 4'hf, 32'h0, modRegsPkg::RESP_OKAY);
        addEntry(opRead,  12'h000, 32'h0, 4'h0, 32'h1234_5678, modRegsPkg::RESP_OKAY);
        addEntry(opWrite, 12'h000, 32'h0000_ab00, 4'h2, 32'h0, modRegsPkg::RESP_OKAY);
        addEntry(opRead,  12'h000, 32'h0, 4'h0, 32'h1234_ab78, modRegsPkg::RESP_OKAY);
        addEntry(opWrite, 12'h004, 32'hffff_ffff, 4'hf, 32'h0, modRegsPkg::RESP_OKAY);
        addEntry(opRead,  12'h004, 32'h0, 4'h0, 32'h0003_ffff, modRegsPkg::RESP_OKAY);
        addEntry(opWrite, 12'h004, 32'h0000_1000, 4'h7, 32'h0, modRegsPkg::RESP_OKAY);
        addEntry(opRead,  12'h004, 32'h0, 4'h0, 32'h0000_1000, modRegsPkg::RESP_OKAY);
        addEntry(opWrite, 12'h00c, 32'hdead_beef, 4'hf, 32'h0, modRegsPkg::RESP_SLVERR);
        addEntry(opRead,  12'h00c, 32'h0, 4'h0, 32'h0, modRegsPkg::RESP_SLVERR);
        addEntry(opRead,  12'h000, 32'h0, 4'h0, 32'h1234_ab78, modRegsPkg::RESP_OKAY);
        addEntry(opRead,  12'h004, 32'h0, 4'h0, 32'h0000_1000, modRegsPkg::RESP_OKAY);
        addEntry(opWrite, 12'h008, 32'h7fff_0003, 4'h1, 32'h0, modRegsPkg::RESP_OKAY);
        addEntry(opRead,  12'h008, 32'h0, 4'h0, 32'h0000_0003, modRegsPkg::RESP_OKAY);
        addEntry(opWrite, 12'h008, 32'h8000_0003, 4'h8, 32'h0, modRegsPkg::RESP_OKAY);
        addEntry(opRun,   12'h000, RUN_BITS, 4'h0, 32'h0, modRegsPkg::RESP_OKAY);
        addEntry(opWrite, 12'h008, 32'h0, 4'h8, 32'h0, modRegsPkg::RESP_OKAY);
        addEntry(opIdle,  12'h000, 32'd8, 4'h0, 32'h0, modRegsPkg::RESP_OKAY);
        addEntry(opWrite, 12'h008, 32'h8000_0006, 4'h9, 32'h0, modRegsPkg::RESP_OKAY);
        addEntry(opRead,  12'h008, 32'h0, 4'h0, 32'h8000_0006, modRegsPkg::RESP_OKAY);
        addEntry(opRun,   12'h000, RUN_BITS, 4'h0, 32'h0, modRegsPkg::RESP_OKAY);
        addEntry(opWrite, 12'h008, 32'h0, 4'h8, 32'h0, modRegsPkg::RESP_OKAY);
        addEntry(opIdle,  12'h000, 32'd8, 4'h0, 32'h0, modRegsPkg::RESP_OKAY);
    endtask

    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        dataBit    <= 1'($random(seed));  // new bit every cycle
        if (cycleCount >= timeoutLimit) begin
            abortRun("Timeout: the test table did not finish within the cycle limit");
        end
    end

    // outputs are settled at the falling edge
    always @(negedge clk) begin
        if (arstN) begin
            checkSym("symOut.sym", soqpskModTop_i.symBeat.sym, mSym);
            checkFreq("instFreq", instFreq, mInst);
            checkFreq("phase", phase, mPhase);
            // state seen by the next rising edge
            mPhase = mPhase + mInst;
            mInst  = freqFor(mSym);
            if (!mEnable) begin
                mA1      = 1'b0;
                mA2      = 1'b0;
                mParity  = soqpskPkg::parityEven;
                mSym     = soqpskPkg::symZero;
                haveLast = 1'b0;
            end else if (bitStrobe) begin
                if (haveLast) begin
                    checkData("strobe interval", 32'(cycleCount - lastStrobe), 32'(mDiv) + 1);
                end
                lastStrobe = cycleCount;
                haveLast   = 1'b1;
                mSym       = predictSym(dataBit);
                mA2        = mA1;
                mA1        = dataBit;
                mParity    = (mParity == soqpskPkg::parityEven) ?
                             soqpskPkg::parityOdd : soqpskPkg::parityEven;
                strobeCount++;
            end
        end
    end

    initial begin
        req   = '0;
        arstN = 1'b0;
        buildTable();
        timeoutLimit = stimTable.size() * (MAX_DIV + 1) * RUN_BITS + 2000;
        repeat (4) @(posedge clk);
        arstN <= 1'b1;
        @(posedge clk);
        foreach (stimTable[i]) begin
            cur = stimTable[i];
            case (cur.op)
                opWrite: begin
                    axiWrite(cur, resp);
                    checkResp("bresp", resp, cur.expResp);
                end
                opRead: begin
                    axiRead(cur.addr, rdData, resp);
                    checkData("rdata", rdData, cur.expData);
                    checkResp("rresp", resp, cur.expResp);
                end
                opRun: begin
                    target = strobeCount + int'(cur.data);
                    while (strobeCount < target) @(posedge clk);
                    repeat (3) @(posedge clk);  // let the last symbol reach instFreq
                end
                default: repeat (cur.data) @(posedge clk);
            endcase
        end
        $display("Result: PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== verilog.f ====
verilog/modRegsPkg.sv
verilog/soqpskPkg.sv
verilog/soqpskModRegs.sv
verilog/bitClockGen.sv
verilog/soqpskPrecoder.sv
verilog/phaseAccum.sv
verilog/soqpskModTop.sv
test/soqpskModChk.sv
test/soqpskModTb.sv

// ==== Bender.yml ====
package:
  name: soqpsk_mod

sources:
  - files:
      - verilog/modRegsPkg.sv
      - verilog/soqpskPkg.sv
      - verilog/soqpskModRegs.sv
      - verilog/bitClockGen.sv
      - verilog/soqpskPrecoder.sv
      - verilog/phaseAccum.sv
      - verilog/soqpskModTop.sv
  - target: test
    files:
      - test/soqpskModChk.sv
      - test/soqpskModTb.sv
